//--- design/ethRxPkg.sv
package ethRxPkg;

    typedef logic [7:0]  ethByte;
    typedef logic [31:0] crcWord;
    typedef logic [15:0] frameLen;   // bytes, FCS included
    typedef logic [15:0] statCount;

    // one frame byte with its position flags
    typedef struct packed {
        logic   valid;
        logic   sof;
        logic   eof;
        ethByte data;
    } rxBeat;

    typedef struct packed {
        logic    done;    // one cycle at end of frame
        logic    crcOk;
        logic    runt;
        frameLen len;
    } frameStatus;

    typedef struct packed {
        statCount goodFrames;
        statCount crcErrFrames;
        statCount runtFrames;
        statCount preambleErrs;
    } ethStats;

    typedef enum logic [1:0] {
        hunt,
        frame,
        drop
    } stripState;

    localparam ethByte  PreambleByte = 8'h55;
    localparam ethByte  SfdByte      = 8'hD5;
    localparam crcWord  CrcInit      = 32'hFFFFFFFF;
    localparam frameLen MinFrameLen  = 16'd64;
    localparam crcWord  CrcPoly      = 32'h04C11DB7;   // 802.3 generator, normal form

    // byte-wise CRC-32 step, byte taken lsb first into a left-shifting register
    function automatic crcWord nextCrc32(ethByte data, crcWord crc);
        crcWord c;
        logic   fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[31] ^ data[i];
            c = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ CrcPoly;
            end
        end
        return c;
    endfunction

endpackage

//--- design/preambleStrip.sv
`timescale 1ns/1ps

module preambleStrip
    import ethRxPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   rxValid,
    input  ethByte rxData,
    output rxBeat  strippedBeat,
    output logic   preambleErr
);

    stripState state;
    logic      seenPreamble;   // at least one 0x55 seen in this burst
    logic      holdValid;
    logic      holdSof;
    ethByte    holdByte;
    logic      outValid;
    logic      outSof;
    logic      outEof;
    ethByte    outData;
    logic      errQ;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state        <= hunt;
            seenPreamble <= 1'b0;
            holdValid    <= 1'b0;
            holdSof      <= 1'b0;
            outValid     <= 1'b0;
            outSof       <= 1'b0;
            outEof       <= 1'b0;
            errQ         <= 1'b0;
        end else begin
            outValid <= 1'b0;
            outSof   <= 1'b0;
            outEof   <= 1'b0;
            errQ     <= 1'b0;
            case (state)
                hunt: begin
                    if (rxValid) begin
                        if (rxData == PreambleByte) begin
                            seenPreamble <= 1'b1;
                        end else if (rxData == SfdByte && seenPreamble) begin
                            state        <= frame;
                            seenPreamble <= 1'b0;
                        end else begin
                            // SFD without preamble, or a stray byte
                            state        <= drop;
                            seenPreamble <= 1'b0;
                            errQ         <= 1'b1;
                        end
                    end else if (seenPreamble) begin
                        seenPreamble <= 1'b0;   // burst ended before any SFD
                        errQ         <= 1'b1;
                    end
                end
                frame: begin
                    if (rxValid) begin
                        holdValid <= 1'b1;
                        holdSof   <= !holdValid;   // first byte after SFD
                        if (holdValid) begin
                            outValid <= 1'b1;
                            outSof   <= holdSof;
                        end
                    end else begin
                        state     <= hunt;
                        holdValid <= 1'b0;
                        if (holdValid) begin
                            outValid <= 1'b1;
                            outSof   <= holdSof;
                            outEof   <= 1'b1;
                        end else begin
                            errQ <= 1'b1;   // nothing behind the SFD
                        end
                    end
                end
                drop: begin
                    if (!rxValid) begin
                        state <= hunt;
                    end
                end
                default: state <= hunt;
            endcase
        end
    end

    // byte path, one hold stage so eof can be decided
    always_ff @(posedge clk) begin
        if (state == frame) begin
            if (rxValid) begin
                holdByte <= rxData;
            end
            outData <= holdByte;
        end
    end

    assign strippedBeat = '{valid: outValid, sof: outSof, eof: outEof, data: outData};
    assign preambleErr  = errQ;

    // a frame never ends on an empty beat, and a new one cannot start right behind it
    assert property (@(posedge clk) disable iff (!rstN)
        strippedBeat.eof |-> strippedBeat.valid ##1 !strippedBeat.valid)
        else $error("eof without valid, or beat directly after eof");

endmodule

//--- design/ethCrcCheck.sv
`timescale 1ns/1ps

module ethCrcCheck
    import ethRxPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  rxBeat      strippedBeat,
    output rxBeat      rxOut,
    output frameStatus status
);

    logic    beatIn;
    logic    outValid;
    logic    outSof;
    logic    outEof;
    ethByte  outData;
    logic    frameOpen;      // between sof and eof
    logic    doneQ;
    crcWord  crcQ;           // running CRC of the current frame
    crcWord  crcBase;
    crcWord  crcHist [4];    // CRC before each of the last four bytes, [0] newest
    ethByte  lastBytes [4];  // [0] newest
    frameLen lenCnt;
    crcWord  rxFcs;
    crcWord  expFcs;
    logic    longEnough;
    logic    fcsMatch;

    assign beatIn  = strippedBeat.valid;
    assign crcBase = strippedBeat.sof ? CrcInit : crcQ;   // a new frame always starts clean

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid  <= 1'b0;
            outSof    <= 1'b0;
            outEof    <= 1'b0;
            frameOpen <= 1'b0;
            doneQ     <= 1'b0;
            crcQ      <= CrcInit;
            lenCnt    <= '0;
        end else begin
            outValid <= beatIn;
            outSof   <= beatIn && strippedBeat.sof;
            outEof   <= beatIn && strippedBeat.eof;
            doneQ    <= beatIn && strippedBeat.eof && (frameOpen || strippedBeat.sof);
            if (beatIn) begin
                if (strippedBeat.eof) begin
                    crcQ <= CrcInit;   // ready for the next frame
                end else begin
                    crcQ <= nextCrc32(strippedBeat.data, crcBase);
                end

                if (strippedBeat.sof) begin
                    lenCnt <= frameLen'(1);
                end else if (lenCnt != '1) begin
                    lenCnt <= lenCnt + 1'b1;
                end

                if (strippedBeat.eof) begin
                    frameOpen <= 1'b0;
                end else if (strippedBeat.sof) begin
                    frameOpen <= 1'b1;
                end
            end
        end
    end

    // byte and history shift
    always_ff @(posedge clk) begin
        outData <= strippedBeat.data;
        if (beatIn) begin
            crcHist[0]   <= crcBase;
            lastBytes[0] <= strippedBeat.data;
            for (int i = 1; i < 4; i++) begin
                crcHist[i]   <= crcHist[i-1];
                lastBytes[i] <= lastBytes[i-1];
            end
        end
    end

    // once the eof byte is in, crcHist[3] covers everything before the FCS
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            expFcs[i] = ~crcHist[3][31-i];
        end
    end

    // FCS arrives least significant byte first
    assign rxFcs      = {lastBytes[0], lastBytes[1], lastBytes[2], lastBytes[3]};
    assign fcsMatch   = (rxFcs == expFcs);
    assign longEnough = (lenCnt >= frameLen'(5));   // FCS plus at least one data byte

    assign rxOut = '{valid: outValid, sof: outSof, eof: outEof, data: outData};

    assign status = '{
        done:  doneQ,
        crcOk: doneQ && longEnough && fcsMatch,
        runt:  doneQ && (lenCnt < MinFrameLen),
        len:   lenCnt
    };

    // an eof only closes a frame that was opened by a sof
    assert property (@(posedge clk) disable iff (!rstN)
        status.done == (rxOut.valid && rxOut.eof))
        else $error("status.done out of step with rxOut eof");

    assert property (@(posedge clk) disable iff (!rstN)
        strippedBeat.valid && strippedBeat.sof |-> !frameOpen)
        else $error("sof arrived inside an open frame");

endmodule

//--- design/frameStats.sv
`timescale 1ns/1ps

module frameStats
    import ethRxPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  frameStatus status,
    input  logic       preambleErr,
    output ethStats    stats
);

    ethStats statsQ;
    logic    goodInc;
    logic    crcErrInc;
    logic    runtInc;

    // counters stick at all ones
    function automatic statCount satInc(statCount value);
        return (value == '1) ? value : value + 1'b1;
    endfunction

    // runt wins over the CRC result
    assign runtInc   = status.done && status.runt;
    assign goodInc   = status.done && !status.runt && status.crcOk;
    assign crcErrInc = status.done && !status.runt && !status.crcOk;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            statsQ <= '0;
        end else begin
            if (goodInc) begin
                statsQ.goodFrames <= satInc(statsQ.goodFrames);
            end
            if (crcErrInc) begin
                statsQ.crcErrFrames <= satInc(statsQ.crcErrFrames);
            end
            if (runtInc) begin
                statsQ.runtFrames <= satInc(statsQ.runtFrames);
            end
            if (preambleErr) begin
                statsQ.preambleErrs <= satInc(statsQ.preambleErrs);
            end
        end
    end

    assign stats = statsQ;

endmodule

//--- design/ethRxTop.sv
`timescale 1ns/1ps

module ethRxTop
    import ethRxPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       rxValid,
    input  ethByte     rxData,
    output rxBeat      rxOut,
    output frameStatus status,
    output ethStats    stats
);

    rxBeat strippedBeat;
    logic  preambleErr;   // one pulse per rejected burst

    // preamble and SFD removal, first/last byte tagging
    preambleStrip i_preambleStrip (
        .clk          (clk),
        .rstN         (rstN),
        .rxValid      (rxValid),
        .rxData       (rxData),
        .strippedBeat (strippedBeat),
        .preambleErr  (preambleErr)
    );

    // FCS check, one more register on the byte stream
    ethCrcCheck i_ethCrcCheck (
        .clk          (clk),
        .rstN         (rstN),
        .strippedBeat (strippedBeat),
        .rxOut        (rxOut),
        .status       (status)
    );

    frameStats i_frameStats (
        .clk          (clk),
        .rstN         (rstN),
        .status       (status),
        .preambleErr  (preambleErr),
        .stats        (stats)
    );

endmodule

//--- tests/tbEthRxModel.svh
`ifndef TB_ETH_RX_MODEL_SVH
`define TB_ETH_RX_MODEL_SVH

// expected output, in the order the DUT must deliver it
rxBeat      expBeats[$];
frameStatus expStatus[$];
ethStats    expStats;

// reflected bit-serial CRC-32 over the first n bytes, returns the FCS value
function automatic crcWord fcsOf(ethByte bytes[$], int n);
    crcWord r;
    ethByte b;
    r = 32'hFFFFFFFF;
    for (int k = 0; k < n; k++) begin
        b = bytes[k];
        for (int i = 0; i < 8; i++) begin
            if (r[0] ^ b[i]) begin
                r = (r >> 1) ^ 32'hEDB88320;   // reversed 802.3 polynomial
            end else begin
                r = r >> 1;
            end
        end
    end
    return ~r;
endfunction

// counters stop at all ones
function automatic statCount bump(statCount v);
    return (v == 16'hFFFF) ? v : v + 16'd1;
endfunction

// frame bytes as they follow the SFD, FCS included
task automatic expectFrame(ethByte bytes[$]);
    int         n;
    crcWord     rxFcs;
    frameStatus st;
    rxBeat      beat;
    n = bytes.size();
    for (int k = 0; k < n; k++) begin
        beat.valid = 1'b1;
        beat.sof   = (k == 0);
        beat.eof   = (k == n - 1);
        beat.data  = bytes[k];
        expBeats.push_back(beat);
    end
    rxFcs    = {bytes[n-1], bytes[n-2], bytes[n-3], bytes[n-4]};   // lsb first on the wire
    st.done  = 1'b1;
    st.len   = frameLen'(n);
    st.runt  = (n < MinFrameLen);
    st.crcOk = (n >= 5) && (fcsOf(bytes, n - 4) == rxFcs);
    expStatus.push_back(st);
    if (st.runt) begin
        expStats.runtFrames = bump(expStats.runtFrames);
    end else if (st.crcOk) begin
        expStats.goodFrames = bump(expStats.goodFrames);
    end else begin
        expStats.crcErrFrames = bump(expStats.crcErrFrames);
    end
endtask

`endif

//--- tests/tbEthRx.sv
`timescale 1ns/1ps

module tbEthRx
    import ethRxPkg::*;
();

    logic        clk;
    logic        rstN;
    logic        rxValid;
    ethByte      rxData;
    rxBeat       rxOut;
    frameStatus  status;
    ethStats     stats;
    logic [31:0] lfsr;
    int          errBeat;
    int          errStatus;
    int          errStats;

    `include "tbEthRxModel.svh"

    ethRxTop i_ethRxTop (
        .clk     (clk),
        .rstN    (rstN),
        .rxValid (rxValid),
        .rxData  (rxData),
        .rxOut   (rxOut),
        .status  (status),
        .stats   (stats)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois form shifting right, taps 32 30 26 25
    function automatic logic stepLfsr();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'hA3000000;
        end
        return out;
    endfunction

    function automatic logic [31:0] takeBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], stepLfsr()};
        end
        return v;
    endfunction

    function automatic int pickRange(int lo, int hi);
        return lo + int'(takeBits(16) % (hi - lo + 1));   // inclusive
    endfunction

    task automatic checkBeat(rxBeat got, rxBeat exp);
        if (got !== exp) begin
            errBeat++;
            $display("Fail %0t: rxOut v%b sof%b eof%b %h, expected v%b sof%b eof%b %h", $time,
                     got.valid, got.sof, got.eof, got.data,
                     exp.valid, exp.sof, exp.eof, exp.data);
        end
    endtask

    task automatic checkStatus(frameStatus got, frameStatus exp);
        if (got !== exp) begin
            errStatus++;
            $display("Fail %0t: status done%b ok%b runt%b len %0d, expected done%b ok%b runt%b len %0d",
                     $time, got.done, got.crcOk, got.runt, got.len,
                     exp.done, exp.crcOk, exp.runt, exp.len);
        end
    endtask

    task automatic checkStats(ethStats got, ethStats exp);
        if (got !== exp) begin
            errStats++;
            $display("Fail %0t: stats %0d/%0d/%0d/%0d, expected %0d/%0d/%0d/%0d", $time,
                     got.goodFrames, got.crcErrFrames, got.runtFrames, got.preambleErrs,
                     exp.goodFrames, exp.crcErrFrames, exp.runtFrames, exp.preambleErrs);
        end
    endtask

    task automatic sendByte(ethByte b);
        @(posedge clk);
        rxValid <= 1'b1;
        rxData  <= b;
    endtask

    task automatic idle(int cycles);
        repeat (cycles) begin
            @(posedge clk);
            rxValid <= 1'b0;
            rxData  <= 8'h00;
        end
    endtask

    // one burst: preamble, SFD, payload, FCS, then a gap
    task automatic runBurst();
        ethByte frameBytes[$];
        int     nPre;
        int     fault;
        int     len;
        int     idx;
        int     badPos;
        crcWord fcs;
        ethByte badByte;
        nPre  = pickRange(1, 7);
        fault = takeBits(3);   // 0 bit flip, 1 bad preamble, 2 runt, rest clean
        len   = (fault == 2) ? pickRange(20, 59) : pickRange(20, 120);
        for (int k = 0; k < len; k++) begin
            frameBytes.push_back(ethByte'(takeBits(8)));
        end
        fcs = fcsOf(frameBytes, len);
        for (int k = 0; k < 4; k++) begin
            frameBytes.push_back(fcs[8*k +: 8]);
        end
        if (fault == 0) begin
            idx = pickRange(0, len + 3);   // payload or FCS
            frameBytes[idx] = frameBytes[idx] ^ ethByte'(1 << takeBits(3));
        end
        badPos  = (fault == 1) ? pickRange(0, nPre - 1) : -1;
        badByte = ethByte'(takeBits(8));
        if (badByte == PreambleByte || badByte == SfdByte) begin
            badByte = badByte ^ 8'h0F;
        end

        if (fault == 1) begin
            expStats.preambleErrs = bump(expStats.preambleErrs);
        end else begin
            expectFrame(frameBytes);
        end

        for (int k = 0; k < nPre; k++) begin
            sendByte((k == badPos) ? badByte : PreambleByte);
        end
        sendByte(SfdByte);
        foreach (frameBytes[k]) begin
            sendByte(frameBytes[k]);
        end
        idle(pickRange(1, 8));
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        rxBeat      expBeat;
        frameStatus expSt;
        if (rstN) begin
            if (rxOut.valid) begin
                if (expBeats.size() == 0) begin
                    errBeat++;
                    $display("rxOut delivered a beat at %0t when no frame byte was expected", $time);
                end else begin
                    expBeat = expBeats.pop_front();
                    checkBeat(rxOut, expBeat);
                    if (expBeat.eof && expStatus.size() != 0) begin
                        expSt = expStatus.pop_front();
                        checkStatus(status, expSt);
                    end
                end
            end
            if (status.done && !(rxOut.valid && rxOut.eof)) begin
                errStatus++;
                $display("Fail %0t: status.done pulsed without an eof beat", $time);
            end
        end
    end

    initial begin
        int   waited;
        logic timedOut;
        lfsr      = 32'h6bbe;
        rstN      = 1'b0;
        rxValid   = 1'b0;
        rxData    = 8'h00;
        errBeat   = 0;
        errStatus = 0;
        errStats  = 0;
        expStats  = '0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        idle(2);

        for (int b = 0; b < 40; b++) begin
            runBurst();
        end

        waited = 0;
        while ((expBeats.size() != 0 || expStatus.size() != 0) && waited < 200) begin
            @(posedge clk);
            waited++;
        end
        timedOut = (expBeats.size() != 0 || expStatus.size() != 0);
        if (timedOut) begin
            $display("timed out waiting for the DUT, %0d frame bytes never came out",
                     expBeats.size());
        end else begin
            repeat (2) @(posedge clk);   // counters land one cycle after the last pulse
            checkStats(stats, expStats);
        end

        $display("errors: beat %0d, status %0d, stats %0d, timeout %0d",
                 errBeat, errStatus, errStats, timedOut);
        if (!timedOut && errBeat + errStatus + errStats == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+tests
design/ethRxPkg.sv
design/preambleStrip.sv
design/ethCrcCheck.sv
design/frameStats.sv
design/ethRxTop.sv
tests/tbEthRx.sv
